// File: flist.f
hdl/disc_pkg.sv
hdl/ram_pkg.sv
hdl/edge_sync.sv
hdl/slot_period_counter.sv
hdl/period_ram.sv
hdl/disc_cycle_stats.sv
tests/tb_disc_cycle_stats.sv

// File: hdl/disc_cycle_stats.sv
`default_nettype none

// Code disc rotation statistics
// Slot periods and slot count per revolution go into a host-readable RAM
module disc_cycle_stats
    import ram_pkg::*;
#(
    parameter int MAX_SLOTS = 59  // Periods kept per revolution
) (
    input  wire       i_clk_50m,
    input  wire       i_rst_n,
    input  wire       i_opto_switch,  // Slot sensor, idles high
    input  wire       i_zero_sign,    // Once-per-revolution mark, idles low
    input  wire ram_addr_t i_ram_raddr,  // Host read address
    input  wire       i_ram_ren,      // Host read enable
    output ram_data_t o_ram_rdata     // One cycle after enable
);

    logic      w_slot_edge;  // Slot rising edge pulse
    logic      w_zero_edge;  // Zero rising edge pulse
    logic      w_ram_we;     // Write strobe to RAM
    ram_addr_t w_ram_waddr;
    ram_data_t w_ram_wdata;

    // ------------------------------------------------------------------------
    // Input synchronizers, equal depth keeps periods exact
    // ------------------------------------------------------------------------
    edge_sync #(
        .RESET_LEVEL (1'b1)          // Opto switch rests high
    ) u_slot_sync (
        .i_clk_50m (i_clk_50m),
        .i_rst_n   (i_rst_n),
        .i_async   (i_opto_switch),
        .o_rise    (w_slot_edge)
    );

    edge_sync #(
        .RESET_LEVEL (1'b0)
    ) u_zero_sync (
        .i_clk_50m (i_clk_50m),
        .i_rst_n   (i_rst_n),
        .i_async   (i_zero_sign),
        .o_rise    (w_zero_edge)
    );

    // ------------------------------------------------------------------------
    // Measurement and storage
    // ------------------------------------------------------------------------
    slot_period_counter #(
        .MAX_SLOTS (MAX_SLOTS)
    ) u_counter (
        .i_clk_50m   (i_clk_50m),
        .i_rst_n     (i_rst_n),
        .i_slot_edge (w_slot_edge),
        .i_zero_edge (w_zero_edge),  // Wins over a coincident slot edge
        .o_we        (w_ram_we),
        .o_waddr     (w_ram_waddr),
        .o_wdata     (w_ram_wdata)
    );

    period_ram u_ram (
        .i_clk_50m (i_clk_50m),
        .i_rst_n   (i_rst_n),
        .i_we      (w_ram_we),
        .i_waddr   (w_ram_waddr),
        .i_wdata   (w_ram_wdata),
        .i_ren     (i_ram_ren),
        .i_raddr   (i_ram_raddr),
        .o_rdata   (o_ram_rdata)
    );

endmodule : disc_cycle_stats

`default_nettype wire

// File: hdl/disc_pkg.sv
`default_nettype none

package disc_pkg;

    // ------------------------------------------------------------------------
    // Code disc measurement widths
    // ------------------------------------------------------------------------

    localparam int PERIOD_W   = 32;  // Clock cycles between two edges
    localparam int SLOT_CNT_W = 8;   // Slot edges per revolution

    // Cycle count between two detected rising edges
    typedef logic [PERIOD_W-1:0] period_t;

    // Slot edges seen since the last zero pulse, saturating
    typedef logic [SLOT_CNT_W-1:0] slot_cnt_t;

    // Counter stops here instead of wrapping to zero
    localparam slot_cnt_t SLOT_CNT_MAX = 8'd255;

endpackage : disc_pkg

`default_nettype wire

// File: hdl/edge_sync.sv
`default_nettype none

// Brings an asynchronous sensor line into the 50 MHz domain
// and flags each low to high transition with a one-cycle pulse
module edge_sync #(
    parameter logic RESET_LEVEL = 1'b0  // Idle level of the sensor line
) (
    input  wire  i_clk_50m,
    input  wire  i_rst_n,
    input  wire  i_async,   // Raw sensor input
    output logic o_rise     // One-cycle rising edge pulse
);

    logic r_sync1;  // First stage, may go metastable
    logic r_sync2;  // Settled copy
    logic r_sync3;  // Previous settled value

    // ------------------------------------------------------------------------
    // Synchronizer chain
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_sync1 <= RESET_LEVEL;  // Idle level, so no false edge
            r_sync2 <= RESET_LEVEL;
            r_sync3 <= RESET_LEVEL;
        end else begin
            r_sync1 <= i_async;
            r_sync2 <= r_sync1;
            r_sync3 <= r_sync2;      // Edge compare stage
        end
    end

    // High for the one cycle where the settled value has just gone up
    assign o_rise = r_sync2 & ~r_sync3;

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // A rise needs a low sample in between, so never two pulses in a row
    a_rise_single : assert property (
        @(posedge i_clk_50m) disable iff (!i_rst_n)
        o_rise |=> !o_rise
    ) else $error("edge_sync: o_rise high on consecutive cycles");

endmodule : edge_sync

`default_nettype wire

// File: hdl/period_ram.sv
`default_nettype none

// 64 x 32 simple dual-port RAM, one write port and one registered read port
module period_ram
    import ram_pkg::*;
(
    input  wire       i_clk_50m,
    input  wire       i_rst_n,
    input  wire       i_we,      // Write strobe
    input  wire ram_addr_t i_waddr,
    input  wire ram_data_t i_wdata,
    input  wire       i_ren,     // Read enable, loads o_rdata
    input  wire ram_addr_t i_raddr,
    output ram_data_t o_rdata    // Held while i_ren is low
);

    ram_data_t r_mem [RAM_DEPTH];  // Storage

    // Contents start cleared
    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            r_mem[i] = '0;
        end
    end

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk_50m) begin
        if (i_we) begin
            r_mem[i_waddr] <= i_wdata;
        end
    end

    // ------------------------------------------------------------------------
    // Read port, same-address access returns the old word
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rdata <= '0;
        end else if (i_ren) begin
            o_rdata <= r_mem[i_raddr];
        end
    end

    // Host must present a clean address whenever it reads
    a_raddr_known : assert property (
        @(posedge i_clk_50m) disable iff (!i_rst_n)
        i_ren |-> !$isunknown(i_raddr)
    ) else $error("period_ram: unknown read address");

endmodule : period_ram

`default_nettype wire

// File: hdl/ram_pkg.sv
`default_nettype none

package ram_pkg;

    // ------------------------------------------------------------------------
    // Statistics RAM geometry
    // ------------------------------------------------------------------------

    localparam int RAM_ADDR_W = 6;                // 64 words
    localparam int RAM_DATA_W = 32;               // One period per word
    localparam int RAM_DEPTH  = 1 << RAM_ADDR_W;  // Word count

    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;    // Word address
    typedef logic [RAM_DATA_W-1:0] ram_data_t;    // Word contents

endpackage : ram_pkg

`default_nettype wire

// File: hdl/slot_period_counter.sv
`default_nettype none

// Measures cycles between slot edges and builds the RAM write stream
// Address 0 gets the slot count per revolution, 1..MAX_SLOTS the periods
module slot_period_counter
    import disc_pkg::*;
    import ram_pkg::*;
#(
    parameter int MAX_SLOTS = 59  // Last period address per revolution
) (
    input  wire       i_clk_50m,
    input  wire       i_rst_n,
    input  wire       i_slot_edge,  // Synchronized slot rising edge
    input  wire       i_zero_edge,  // Synchronized zero rising edge
    output logic      o_we,         // Single-cycle write strobe
    output ram_addr_t o_waddr,      // Write address
    output ram_data_t o_wdata       // Write data
);

    period_t   r_period;     // Cycles since last stored edge
    slot_cnt_t r_slot_cnt;   // Slot edges this revolution
    slot_cnt_t w_slot_next;  // Saturating increment of the count
    logic      w_store;      // Slot edge that still has a RAM word

    // ------------------------------------------------------------------------
    // Next count and store decision
    // ------------------------------------------------------------------------

    // Holds at the top instead of wrapping
    assign w_slot_next = (r_slot_cnt == SLOT_CNT_MAX) ? r_slot_cnt
                                                      : r_slot_cnt + 1'b1;

    // Old count below the limit means address old+1 is still free
    assign w_store = i_slot_edge && (r_slot_cnt < slot_cnt_t'(MAX_SLOTS));

    // ------------------------------------------------------------------------
    // Period and slot counters
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_period   <= '0;
            r_slot_cnt <= '0;
        end else if (i_zero_edge) begin
            // New revolution, a coincident slot edge is dropped
            r_period   <= '0;
            r_slot_cnt <= '0;
        end else if (i_slot_edge) begin
            r_slot_cnt <= w_slot_next;
            if (w_store) begin
                r_period <= '0;               // Restart from this edge
            end else begin
                r_period <= r_period + 1'b1;  // Past the limit, keep counting
            end
        end else begin
            r_period <= r_period + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Registered write port
    // ------------------------------------------------------------------------

    // Strobe lasts exactly one cycle per qualifying edge
    always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_we <= 1'b0;
        end else begin
            o_we <= i_zero_edge || w_store;
        end
    end

    // Count word on a zero edge, period word on a stored slot edge
    always_ff @(posedge i_clk_50m) begin
        if (i_zero_edge) begin
            o_waddr <= '0;                        // Count word
            o_wdata <= ram_data_t'(r_slot_cnt);   // Edges of the revolution just ended
        end else if (w_store) begin
            o_waddr <= ram_addr_t'(w_slot_next);  // Below the limit, no saturation here
            o_wdata <= ram_data_t'(r_period);     // Edge distance minus one
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // Slot addresses 1..MAX_SLOTS must fit behind the count word
    a_max_slots_fit : assert property (
        @(posedge i_clk_50m) disable iff (!i_rst_n)
        (MAX_SLOTS >= 1) && (MAX_SLOTS < RAM_DEPTH)
    ) else $error("slot_period_counter: MAX_SLOTS %0d out of range", MAX_SLOTS);

    // No period ever lands above the configured limit
    a_waddr_range : assert property (
        @(posedge i_clk_50m) disable iff (!i_rst_n)
        o_we |-> (o_waddr <= ram_addr_t'(MAX_SLOTS))
    ) else $error("slot_period_counter: write to address %0d", o_waddr);

endmodule : slot_period_counter

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the disc statistics testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_disc_cycle_stats
OBJ_DIR=obj_dir
LOG=sim.log
PASS_LINE='*** TEST PASSED ***'

# Build
verilator --binary --timing --assert \
    -f flist.f \
    --top-module "${TOP}" \
    -Mdir "${OBJ_DIR}"
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

# Run
"./${OBJ_DIR}/V${TOP}" > "${LOG}" 2>&1
status=$?
cat "${LOG}"
if [ ${status} -ne 0 ]; then
    echo "run_sim: simulation exited with status ${status}"
    exit 1
fi

# Verdict from the log
grep -F -q -x "${PASS_LINE}" "${LOG}"
if [ $? -ne 0 ]; then
    echo "run_sim: pass line not found in ${LOG}"
    exit 1
fi

echo "run_sim: simulation passed"
exit 0

// File: tests/tb_disc_cycle_stats.sv
`default_nettype none

// Code disc statistics testbench
// Slot and zero pulses in, RAM read back against a shadow copy
module tb_disc_cycle_stats
    import ram_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------------------------------------------------
    // Test constants
    // ------------------------------------------------------------------------
    localparam int MAX_SLOTS    = 59;
    localparam int RESET_CYCLES = 16;
    localparam int HIGH_CYCLES  = 3;   // Pulse high time
    localparam int GAP_MIN      = 6;   // 3 high plus 3 low at least
    localparam int GAP_MAX      = 40;
    localparam int IDLE_CYCLES  = 10;  // Write pipeline drains

    // About 110 gaps of at most 40 cycles plus 5 read-backs of ~90,
    // doubled and rounded up with margin
    localparam int TIMEOUT_CYCLES = 20_000;

    logic      clk_50m;
    logic      rst_n;
    logic      opto_switch;
    logic      zero_sign;
    ram_addr_t ram_raddr;
    logic      ram_ren;
    ram_data_t ram_rdata;

    ram_data_t  shadow [RAM_DEPTH];  // Expected RAM contents
    int         ev_time [$];         // Cycle of each driven rising edge
    logic [1:0] ev_mask [$];         // Bit 0 slot, bit 1 zero
    int         ref_last;            // Edge that started the running period
    int         ref_cnt;             // Slot count of the running revolution
    logic [31:0] rng_state;

    int        cyc = 0;              // Free-running cycle count
    logic      chk_ren = 1'b0;       // Enable seen by the RAM last edge
    ram_addr_t chk_addr = '0;
    ram_data_t exp_rdata = '0;       // Model of the read register
    string     cur_test = "reset";
    int        test_errors = 0;
    int        total_errors = 0;
    int        n_checks = 0;
    int        n_tests = 0;
    int        n_failed_tests = 0;

    disc_cycle_stats #(
        .MAX_SLOTS (MAX_SLOTS)
    ) disc_cycle_stats_inst (
        .i_clk_50m     (clk_50m),
        .i_rst_n       (rst_n),
        .i_opto_switch (opto_switch),
        .i_zero_sign   (zero_sign),
        .i_ram_raddr   (ram_raddr),
        .i_ram_ren     (ram_ren),
        .o_ram_rdata   (ram_rdata)
    );

    always #10 clk_50m = ~clk_50m;  // 50 MHz

    // Run limit
    always @(posedge clk_50m) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, test %s never finished", cyc, cur_test);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Random gaps and reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function int next_gap();
        rng_state = xorshift32(rng_state);
        return GAP_MIN + int'(rng_state % (GAP_MAX - GAP_MIN + 1));
    endfunction

    // Walks the recorded edges through the write rules
    function void apply_edges();
        ram_addr_t addr;
        for (int i = 0; i < ev_time.size(); i++) begin
            if (ev_mask[i][1]) begin
                shadow[0] = ram_data_t'(ref_cnt);  // Zero wins, slot dropped
                ref_cnt   = 0;
                ref_last  = ev_time[i];
            end else if (ev_mask[i][0]) begin
                if (ref_cnt < MAX_SLOTS) begin
                    addr         = ram_addr_t'(ref_cnt + 1);
                    shadow[addr] = ram_data_t'(ev_time[i] - ref_last - 1);
                    ref_last     = ev_time[i];
                end
                if (ref_cnt < 255) begin
                    ref_cnt = ref_cnt + 1;  // Saturating
                end
            end
        end
        ev_time.delete();
        ev_mask.delete();
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------

    // Rising edge now, next call's edge exactly gap cycles later
    task automatic drive_pulse(input logic [1:0] mask, input int gap);
        @(posedge clk_50m);
        if (mask[0]) begin
            opto_switch <= 1'b1;
        end
        if (mask[1]) begin
            zero_sign <= 1'b1;
        end
        ev_time.push_back(cyc);
        ev_mask.push_back(mask);
        repeat (HIGH_CYCLES) @(posedge clk_50m);
        opto_switch <= 1'b0;
        zero_sign   <= 1'b0;
        repeat (gap - HIGH_CYCLES - 1) @(posedge clk_50m);
    endtask

    task automatic run_revolution(input int n_slots, input bit lead_zero);
        if (lead_zero) begin
            drive_pulse(2'b10, next_gap());
        end
        for (int i = 0; i < n_slots; i++) begin
            drive_pulse(2'b01, next_gap());
        end
        drive_pulse(2'b10, next_gap());  // Closes the revolution
    endtask

    // Reads 63 down to 0, then moves the address with enable low
    task automatic read_back();
        apply_edges();
        repeat (IDLE_CYCLES) @(posedge clk_50m);
        for (int a = RAM_DEPTH - 1; a >= 0; a--) begin
            @(posedge clk_50m);
            ram_raddr <= ram_addr_t'(a);
            ram_ren   <= 1'b1;
        end
        @(posedge clk_50m);
        ram_ren <= 1'b0;
        for (int a = 0; a < 8; a++) begin
            @(posedge clk_50m);
            ram_raddr <= ram_addr_t'(a * 5 + 1);  // Data must hold the count word
        end
        repeat (2) @(posedge clk_50m);
    endtask

    task automatic finish_test();
        n_tests = n_tests + 1;
        if (test_errors != 0) begin
            n_failed_tests = n_failed_tests + 1;
        end
        $display("Test %0d %-12s %s, %0d errors", n_tests, cur_test,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        total_errors = total_errors + test_errors;
        test_errors  = 0;
    endtask

    // ------------------------------------------------------------------------
    // Read port comparison
    // ------------------------------------------------------------------------
    always @(posedge clk_50m) begin
        chk_ren  <= ram_ren;    // What the RAM sampled on this edge
        chk_addr <= ram_raddr;
    end

    // Checked mid-cycle, read data is settled there
    always @(negedge clk_50m) begin
        if (rst_n) begin
            if (chk_ren) begin
                exp_rdata = shadow[chk_addr];
            end
            n_checks = n_checks + 1;
            assert (ram_rdata === exp_rdata) else begin
                $display("[FAIL] %s addr %0d%s expected %0h actual %0h", cur_test,
                         chk_addr, chk_ren ? "" : " held", exp_rdata, ram_rdata);
                test_errors = test_errors + 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        clk_50m     = 1'b0;
        rst_n       = 1'b0;
        opto_switch = 1'b1;  // Slot sensor idle level
        zero_sign   = 1'b0;
        ram_raddr   = '0;
        ram_ren     = 1'b0;
        rng_state   = 32'hd3a3;
        ref_last    = 0;
        ref_cnt     = 0;
        foreach (shadow[i]) begin
            shadow[i] = '0;  // RAM starts cleared
        end

        repeat (RESET_CYCLES) @(posedge clk_50m);
        rst_n <= 1'b1;
        @(posedge clk_50m);
        opto_switch <= 1'b0;  // Falling only, no edge

        cur_test = "reset_read";
        read_back();
        finish_test();

        cur_test = "one_rev";
        run_revolution(12, 1'b1);
        read_back();
        finish_test();

        cur_test = "slot_limit";
        run_revolution(70, 1'b1);  // 11 slots past the limit
        read_back();
        finish_test();

        cur_test = "zero_restart";
        run_revolution(12, 1'b1);
        run_revolution(3, 1'b0);   // Short revolution right after
        read_back();
        finish_test();

        cur_test = "coincident";
        drive_pulse(2'b10, next_gap());
        for (int i = 0; i < 4; i++) begin
            drive_pulse(2'b01, next_gap());
        end
        drive_pulse(2'b11, next_gap());  // Slot and zero on one edge
        for (int i = 0; i < 2; i++) begin
            drive_pulse(2'b01, next_gap());
        end
        read_back();
        finish_test();

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 n_tests, n_failed_tests, n_checks, total_errors);
        if (total_errors == 0 && n_failed_tests == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_disc_cycle_stats

`default_nettype wire
